// File: bench/transducer_patterns.txt
# kind word_addr wdata be pieces size0 addr0 data0 size1 addr1 data1 ret_data0 expect
# expect is the read word for rd lines and the ao486_int pulse count for int lines
wr 00000400 11223344 f 1 2 0000001000 44332211 0 0000000000 00000000 0000000000000000 00000000
wr 00000401 a1b2c3d4 1 1 0 0000001004 000000d4 0 0000000000 00000000 0000000000000000 00000000
wr 00000402 a1b2c3d4 2 1 0 0000001009 000000c3 0 0000000000 00000000 0000000000000000 00000000
wr 00000403 a1b2c3d4 4 1 0 000000100e 000000b2 0 0000000000 00000000 0000000000000000 00000000
wr 00000404 a1b2c3d4 8 1 0 0000001013 000000a1 0 0000000000 00000000 0000000000000000 00000000
wr 00000405 55667788 3 1 1 0000001014 00008877 0 0000000000 00000000 0000000000000000 00000000
wr 00000406 55667788 c 1 1 000000101a 00006655 0 0000000000 00000000 0000000000000000 00000000
wr 00000407 cafef00d 7 2 1 000000101c 00000df0 0 000000101e 000000fe 0000000000000000 00000000
wr 00000408 cafef00d e 2 0 0000001021 000000f0 1 0000001022 0000feca 0000000000000000 00000000
wr 00000409 cafef00d 6 2 0 0000001025 000000f0 0 0000001026 000000fe 0000000000000000 00000000
wr 20000010 0badf00d f 1 2 0080000040 0df0ad0b 0 0000000000 00000000 0000000000000000 00000000
wr 20000011 0badf00d 7 2 1 0080000044 00000df0 0 0080000046 000000ad 0000000000000000 00000000
rd 00000400 00000000 f 1 2 0000001000 00000000 0 0000000000 00000000 1122334455667788 44332211
rd 00000401 00000000 f 1 2 0000001004 00000000 0 0000000000 00000000 1122334455667788 88776655
rd 3fffffff 00000000 f 1 2 00fffffffc 00000000 0 0000000000 00000000 deadbeef01234567 67452301
int 00000000 00000000 0 0 0 0000000000 00000000 0 0000000000 00000000 0000000000010000 00000001
int 00000000 00000000 0 0 0 0000000000 00000000 0 0000000000 00000000 0000000000020000 00000000
int 00000000 00000000 0 0 0 0000000000 00000000 0 0000000000 00000000 fffffffffffdffff 00000001

// File: filelist.f
+incdir+bench
source/transducer_pkg.sv
source/cpu_req_capture.sv
source/store_splitter.sv
source/l15_issue.sv
source/l15_return_decode.sv
source/ao486_l15_transducer.sv
bench/tb_transducer.sv

// File: Bender.yml
package:
  name: ao486_l15_transducer

sources:
  - files:
      - source/transducer_pkg.sv
      - source/cpu_req_capture.sv
      - source/store_splitter.sv
      - source/l15_issue.sv
      - source/l15_return_decode.sv
      - source/ao486_l15_transducer.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_transducer.sv

// File: bench/tb_checks.svh
/*
 * Compare tasks and the random source for the transducer testbench.
 * Included inside tb_transducer, where error_count and rng_state live.
 * Only the request fields visible on the cache port are compared.
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// xorshift32 with its state in rng_state
function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

task automatic check_piece(input int idx, input transducer_pkg::l15_req_t exp,
                           input transducer_pkg::l15_req_t act);
    if (act !== exp) begin
        error_count++;
        $display("error transducer_l15 piece %0d: expected rqtype %h size %h address %h data %h nc %h",
                 idx, exp.rqtype, exp.size, exp.address, exp.data, exp.nc);
        $display("error transducer_l15 piece %0d: got rqtype %h size %h address %h data %h nc %h",
                 idx, act.rqtype, act.size, act.address, act.data, act.nc);
    end
endtask

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
        error_count++;
        $display("error %s: expected %h got %h", name, exp, act);
    end
endtask

task automatic check_int(input int exp, input int act);
    if (act != exp) begin
        error_count++;
        $display("error ao486_int pulse count: expected %h got %h", exp, act);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        error_count++;
        $display("error %s: expected %h got %h", name, exp, act);
    end
endtask

`endif

// File: bench/tb_transducer.sv
/*
 * Testbench for ao486_l15_transducer, run from the project root.
 * Operations come from bench/transducer_patterns.txt, one per line.
 * The cache model acks after 0 to 3 idle cycles and answers every
 * request two cycles after its ack, loads with load_ret, stores with st_ack.
 * All inputs are driven and outputs sampled 2 ns after the rising edge.
 */
module tb_transducer;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        int kind;
        logic [transducer_pkg::cpu_addr_width-1:0] addr;
        logic [31:0] wdata;
        logic [3:0] be;
        int n;
        logic [2:0] sz0;
        logic [transducer_pkg::phys_addr_width-1:0] pa0;
        logic [31:0] pd0;
        logic [2:0] sz1;
        logic [transducer_pkg::phys_addr_width-1:0] pa1;
        logic [31:0] pd1;
        logic [63:0] ret_data;
        logic [31:0] exp_val;
    } op_t;

    typedef struct {
        int due;
        logic [3:0] rtype;
        logic [63:0] data;
    } ret_t;

    logic clk;
    logic rst_n;
    logic [transducer_pkg::cpu_addr_width-1:0] ao486_transducer_mem_address;
    logic [31:0] ao486_transducer_mem_writedata;
    logic [3:0] ao486_transducer_mem_byteenable;
    logic ao486_transducer_mem_write;
    logic ao486_transducer_mem_read;
    logic transducer_ao486_mem_waitrequest;
    logic transducer_ao486_mem_readdatavalid;
    logic [31:0] transducer_ao486_mem_readdata;
    logic l15_transducer_ack;
    logic [4:0] transducer_l15_rqtype;
    logic [2:0] transducer_l15_size;
    logic transducer_l15_val;
    logic [transducer_pkg::phys_addr_width-1:0] transducer_l15_address;
    logic [63:0] transducer_l15_data;
    logic transducer_l15_nc;
    logic l15_transducer_val;
    logic [3:0] l15_transducer_returntype;
    logic [63:0] l15_transducer_data_0;
    logic transducer_l15_req_ack;
    logic ao486_int;

    int error_count;
    int cycle_count;
    logic [31:0] rng_state;
    op_t ops[$];
    logic ops_loaded;

    ret_t ret_q[$];
    transducer_pkg::l15_req_t got_pieces[$];
    transducer_pkg::l15_req_t held;
    logic holding;
    int wait_left;
    int last_ack_cycle;
    int load_ret_cycle;
    logic [63:0] load_data;
    int int_count;
    int rdv_count;

    `include "tb_checks.svh"

    ao486_l15_transducer uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic cache_model_step();
        transducer_pkg::l15_req_t cur;
        ret_t r;
        check_bit("transducer_l15_req_ack", l15_transducer_val, transducer_l15_req_ack);
        if (ao486_int) int_count++;
        if (transducer_ao486_mem_readdatavalid) rdv_count++;
        if (ret_q.size() > 0 && ret_q[0].due == cycle_count) begin
            l15_transducer_val = 1'b1;
            l15_transducer_returntype = ret_q[0].rtype;
            l15_transducer_data_0 = ret_q[0].data;
            if (ret_q[0].rtype == transducer_pkg::load_ret) load_ret_cycle = cycle_count;
            ret_q.delete(0);
        end else begin
            l15_transducer_val = 1'b0;
        end
        cur = '0;
        cur.rqtype = transducer_l15_rqtype;
        cur.size = transducer_l15_size;
        cur.address = transducer_l15_address;
        cur.data = transducer_l15_data[31:0];
        cur.nc = transducer_l15_nc;
        if (!transducer_l15_val) begin
            l15_transducer_ack = 1'b0;
            if (holding) begin
                error_count++;
                $display("cache request valid dropped before it was acknowledged");
                holding = 1'b0;
            end
            return;
        end
        if (transducer_l15_data[63:32] !== transducer_l15_data[31:0]) begin
            error_count++;
            $display("error transducer_l15_data: upper half %h lower half %h",
                     transducer_l15_data[63:32], transducer_l15_data[31:0]);
        end
        if (!holding) begin
            held = cur;
            holding = 1'b1;
            wait_left = int'(next_random() & 32'd3);
        end else if (cur !== held) begin
            error_count++;
            $display("cache request fields changed while waiting for the ack");
        end
        if (wait_left == 0) begin
            l15_transducer_ack = 1'b1;
            holding = 1'b0;
            got_pieces.push_back(cur);
            last_ack_cycle = cycle_count;
            r.due = cycle_count + 2;
            if (cur.rqtype == transducer_pkg::load_rq) begin
                r.rtype = transducer_pkg::load_ret;
                r.data = load_data;
            end else begin
                // wakeup bits on a store ack must not raise the interrupt
                r.rtype = transducer_pkg::st_ack;
                r.data = 64'h0000_0000_0001_0000;
            end
            ret_q.push_back(r);
        end else begin
            l15_transducer_ack = 1'b0;
            wait_left--;
        end
    endtask

    task automatic advance_cycle();
        @(posedge clk);
        #2;
        cycle_count++;
        cache_model_step();
    endtask

    function automatic transducer_pkg::l15_req_t expected_piece(input op_t op, input int idx);
        transducer_pkg::l15_req_t p;
        p = '0;
        p.rqtype = (op.kind == 1) ? transducer_pkg::store_rq : transducer_pkg::load_rq;
        p.size = (idx == 0) ? op.sz0 : op.sz1;
        p.address = (idx == 0) ? op.pa0 : op.pa1;
        p.data = (idx == 0) ? op.pd0 : op.pd1;
        p.nc = op.addr[transducer_pkg::cpu_addr_width-1];
        return p;
    endfunction

    task automatic drain_returns();
        while (ret_q.size() > 0) advance_cycle();
        repeat (2) advance_cycle();
    endtask

    task automatic run_access(input op_t op);
        int int_before;
        int rdv_before;
        got_pieces.delete();
        int_before = int_count;
        rdv_before = rdv_count;
        load_data = op.ret_data;
        ao486_transducer_mem_address = op.addr;
        ao486_transducer_mem_writedata = op.wdata;
        ao486_transducer_mem_byteenable = op.be;
        ao486_transducer_mem_write = (op.kind == 1);
        ao486_transducer_mem_read = (op.kind == 0);
        advance_cycle();
        ao486_transducer_mem_write = 1'b0;
        ao486_transducer_mem_read = 1'b0;
        while (transducer_ao486_mem_waitrequest) advance_cycle();
        if (op.kind == 1) begin
            if (cycle_count - last_ack_cycle != 1) begin
                error_count++;
                $display("waitrequest did not fall one cycle after the last store ack");
            end
        end else begin
            check_bit("transducer_ao486_mem_readdatavalid", 1'b1,
                      transducer_ao486_mem_readdatavalid);
            check_word("transducer_ao486_mem_readdata", op.exp_val, transducer_ao486_mem_readdata);
            if (cycle_count - load_ret_cycle != 1) begin
                error_count++;
                $display("read data did not arrive one cycle after the load return");
            end
        end
        drain_returns();
        if (got_pieces.size() != op.n) begin
            error_count++;
            $display("wrong number of cache requests: expected %0d, saw %0d",
                     op.n, got_pieces.size());
        end else begin
            for (int i = 0; i < op.n; i++) check_piece(i, expected_piece(op, i), got_pieces[i]);
        end
        if (rdv_count - rdv_before != ((op.kind == 0) ? 1 : 0)) begin
            error_count++;
            $display("readdatavalid pulsed %0d times for one access", rdv_count - rdv_before);
        end
        check_int(0, int_count - int_before);
    endtask

    task automatic run_interrupt(input op_t op);
        ret_t r;
        int int_before;
        got_pieces.delete();
        int_before = int_count;
        r.due = cycle_count + 1;
        r.rtype = transducer_pkg::int_ret;
        r.data = op.ret_data;
        ret_q.push_back(r);
        drain_returns();
        check_int(int'(op.exp_val), int_count - int_before);
        if (got_pieces.size() != 0) begin
            error_count++;
            $display("an interrupt return caused a cache request");
        end
    endtask

    task automatic read_patterns();
        int fd;
        int cnt;
        string line;
        string kind;
        op_t op;
        fd = $fopen("bench/transducer_patterns.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("cannot open bench/transducer_patterns.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            cnt = $sscanf(line, "%s %h %h %h %d %h %h %h %h %h %h %h %h", kind, op.addr,
                          op.wdata, op.be, op.n, op.sz0, op.pa0, op.pd0, op.sz1, op.pa1,
                          op.pd1, op.ret_data, op.exp_val);
            if (cnt != 13 || !(kind == "wr" || kind == "rd" || kind == "int")) begin
                error_count++;
                $display("unreadable pattern line: %s", line);
                continue;
            end
            op.kind = (kind == "rd") ? 0 : (kind == "wr") ? 1 : 2;
            ops.push_back(op);
        end
        $fclose(fd);
    endtask

    initial begin
        error_count = 0;
        cycle_count = 0;
        rng_state = 32'he5fa_34b7;
        ops_loaded = 1'b0;
        holding = 1'b0;
        wait_left = 0;
        last_ack_cycle = 0;
        load_ret_cycle = 0;
        load_data = '0;
        int_count = 0;
        rdv_count = 0;
        rst_n = 1'b0;
        ao486_transducer_mem_address = '0;
        ao486_transducer_mem_writedata = '0;
        ao486_transducer_mem_byteenable = '0;
        ao486_transducer_mem_write = 1'b0;
        ao486_transducer_mem_read = 1'b0;
        l15_transducer_ack = 1'b0;
        l15_transducer_val = 1'b0;
        l15_transducer_returntype = '0;
        l15_transducer_data_0 = '0;
        read_patterns();
        ops_loaded = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        advance_cycle();
        // idle outputs before the first request
        check_bit("transducer_l15_val", 1'b0, transducer_l15_val);
        check_bit("transducer_ao486_mem_readdatavalid", 1'b0, transducer_ao486_mem_readdatavalid);
        check_bit("ao486_int", 1'b0, ao486_int);
        check_bit("transducer_ao486_mem_waitrequest", 1'b0, transducer_ao486_mem_waitrequest);
        foreach (ops[i]) begin
            if (ops[i].kind == 2) run_interrupt(ops[i]);
            else run_access(ops[i]);
        end
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // about 40 cycles per operation is plenty even with slow acks
    initial begin
        wait (ops_loaded);
        repeat (ops.size() * 40 + 100) @(posedge clk);
        $display("timeout: operations did not complete within %0d cycles, errors: %0d",
                 ops.size() * 40 + 100, error_count);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: source/ao486_l15_transducer.sv
/*
 * Bridge from the ao486 Avalon memory port to the OpenPiton L1.5 port.
 * Single-beat reads and writes only; no bursts, fills or I/O bus.
 * One CPU access is in flight at a time, at most two cache pieces.
 * Unused L1.5 request fields are left to the integration to tie off.
 */
module ao486_l15_transducer (
    input  logic clk,
    input  logic rst_n,

    // ao486 memory bus
    input  logic [transducer_pkg::cpu_addr_width-1:0] ao486_transducer_mem_address,
    input  logic [31:0] ao486_transducer_mem_writedata,
    input  logic [3:0] ao486_transducer_mem_byteenable,
    input  logic ao486_transducer_mem_write,
    input  logic ao486_transducer_mem_read,
    output logic transducer_ao486_mem_waitrequest,
    output logic transducer_ao486_mem_readdatavalid,
    output logic [31:0] transducer_ao486_mem_readdata,

    // L1.5 request port
    input  logic l15_transducer_ack,
    output logic [4:0] transducer_l15_rqtype,
    output logic [2:0] transducer_l15_size,
    output logic transducer_l15_val,
    output logic [transducer_pkg::phys_addr_width-1:0] transducer_l15_address,
    output logic [63:0] transducer_l15_data,
    output logic transducer_l15_nc,

    // L1.5 return port
    input  logic l15_transducer_val,
    input  logic [3:0] l15_transducer_returntype,
    input  logic [63:0] l15_transducer_data_0,
    output logic transducer_l15_req_ack,
    output logic ao486_int
);

    transducer_pkg::cpu_req_t req;
    transducer_pkg::l15_req_t piece;
    logic req_start;
    logic piece_valid;
    logic piece_ready;
    logic store_done;
    logic load_done;
    logic [31:0] load_word;

    cpu_req_capture u_capture (
        .clk(clk),
        .rst_n(rst_n),
        .mem_address(ao486_transducer_mem_address),
        .mem_writedata(ao486_transducer_mem_writedata),
        .mem_byteenable(ao486_transducer_mem_byteenable),
        .mem_read(ao486_transducer_mem_read),
        .mem_write(ao486_transducer_mem_write),
        .store_done(store_done),
        .load_done(load_done),
        .load_word(load_word),
        .waitrequest(transducer_ao486_mem_waitrequest),
        .readdatavalid(transducer_ao486_mem_readdatavalid),
        .readdata(transducer_ao486_mem_readdata),
        .req(req),
        .req_start(req_start)
    );

    store_splitter u_splitter (
        .clk(clk),
        .rst_n(rst_n),
        .req(req),
        .req_start(req_start),
        .piece_ready(piece_ready),
        .piece(piece),
        .piece_valid(piece_valid)
    );

    l15_issue u_issue (
        .clk(clk),
        .rst_n(rst_n),
        .piece(piece),
        .piece_valid(piece_valid),
        .l15_ack(l15_transducer_ack),
        .piece_ready(piece_ready),
        .l15_val(transducer_l15_val),
        .l15_rqtype(transducer_l15_rqtype),
        .l15_size(transducer_l15_size),
        .l15_address(transducer_l15_address),
        .l15_data(transducer_l15_data),
        .l15_nc(transducer_l15_nc),
        .store_done(store_done)
    );

    // byte address bit 2 is word address bit 0
    l15_return_decode u_return (
        .clk(clk),
        .rst_n(rst_n),
        .l15_val(l15_transducer_val),
        .l15_returntype(l15_transducer_returntype),
        .l15_data_0(l15_transducer_data_0),
        .read_addr_bit2(req.word_addr[0]),
        .req_ack(transducer_l15_req_ack),
        .load_done(load_done),
        .load_word(load_word),
        .ao486_int(ao486_int)
    );

endmodule

// File: source/l15_return_decode.sv
/*
 * Takes every L1.5 return in the cycle it is valid.
 * Load data comes from data_0 only, since loads never cross a word.
 * Store acks and non-wakeup interrupts are dropped.
 */
module l15_return_decode (
    input  logic clk,
    input  logic rst_n,
    input  logic l15_val,
    input  logic [3:0] l15_returntype,
    input  logic [63:0] l15_data_0,
    input  logic read_addr_bit2,
    output logic req_ack,
    output logic load_done,
    output logic [31:0] load_word,
    output logic ao486_int
);

    logic [31:0] half;
    logic wakeup;

    assign req_ack = l15_val;
    assign load_done = l15_val && (l15_returntype == transducer_pkg::load_ret);

    // big-endian puts the even word in the upper half
    assign half = read_addr_bit2 ? l15_data_0[31:0] : l15_data_0[63:32];
    assign load_word = {half[7:0], half[15:8], half[23:16], half[31:24]};

    assign wakeup = l15_val && (l15_returntype == transducer_pkg::int_ret)
        && (l15_data_0[transducer_pkg::int_type_lsb +: 2] == transducer_pkg::int_wakeup);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ao486_int <= 1'b0;
        end else begin
            ao486_int <= wakeup;
        end
    end

endmodule

// File: source/l15_issue.sv
/*
 * Drives the L1.5 request port from a one-entry request register.
 * val stays high with stable fields until the cache acks.
 * A new piece loads in the ack cycle, so back-to-back pieces need no gap.
 * store_done pulses one cycle after the ack of a last store piece.
 */
module l15_issue (
    input  logic clk,
    input  logic rst_n,
    input  transducer_pkg::l15_req_t piece,
    input  logic piece_valid,
    input  logic l15_ack,
    output logic piece_ready,
    output logic l15_val,
    output logic [4:0] l15_rqtype,
    output logic [2:0] l15_size,
    output logic [transducer_pkg::phys_addr_width-1:0] l15_address,
    output logic [63:0] l15_data,
    output logic l15_nc,
    output logic store_done
);

    transducer_pkg::l15_req_t req_q;
    logic load;

    assign piece_ready = !l15_val || l15_ack;
    assign load = piece_valid && piece_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            l15_val <= 1'b0;
            store_done <= 1'b0;
        end else begin
            store_done <= l15_val && l15_ack && req_q.last && req_q.is_store;
            if (load) begin
                l15_val <= 1'b1;
            end else if (l15_ack) begin
                l15_val <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            req_q <= piece;
        end
    end

    assign l15_rqtype = req_q.rqtype;
    assign l15_size = req_q.size;
    assign l15_address = req_q.address;
    // cache picks the lane from the address, so mirror both halves
    assign l15_data = {req_q.data, req_q.data};
    assign l15_nc = req_q.nc;

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        l15_val && !l15_ack |=> l15_val && $stable(l15_address) && $stable(l15_data));

endmodule

// File: source/store_splitter.sv
/*
 * Turns a held CPU request into one or two cache request pieces.
 * Writes are split by byte enable into naturally aligned stores.
 * Legal enables are contiguous runs and 4'b0110; others are flagged.
 * Reads always become one 4-byte load at the word base.
 * The request must stay stable until its last piece is taken.
 */
module store_splitter (
    input  logic clk,
    input  logic rst_n,
    input  transducer_pkg::cpu_req_t req,
    input  logic req_start,
    input  logic piece_ready,
    output transducer_pkg::l15_req_t piece,
    output logic piece_valid
);

    logic [transducer_pkg::phys_addr_width-1:0] base;
    transducer_pkg::l15_req_t p0;
    transducer_pkg::l15_req_t p1;
    logic two;
    logic second_pending;
    logic take;

    // byte lane k lives at base + k
    assign base = {8'b0, req.word_addr, 2'b00};
    assign take = piece_valid && piece_ready;

    function automatic transducer_pkg::l15_req_t store_piece(
        input logic [2:0] size,
        input logic [1:0] lane,
        input logic last
    );
        transducer_pkg::l15_req_t p;
        p.rqtype = transducer_pkg::store_rq;
        p.size = size;
        p.address = {base[transducer_pkg::phys_addr_width-1:2], lane};
        p.nc = req.word_addr[transducer_pkg::cpu_addr_width-1];
        p.last = last;
        p.is_store = 1'b1;
        // lowest address goes to the most significant byte
        case (size)
            transducer_pkg::sz_1b: p.data = {24'b0, req.wdata[8*lane +: 8]};
            transducer_pkg::sz_2b: p.data = {16'b0, req.wdata[8*lane +: 8],
                                             req.wdata[8*lane+8 +: 8]};
            default: p.data = {req.wdata[7:0], req.wdata[15:8],
                               req.wdata[23:16], req.wdata[31:24]};
        endcase
        return p;
    endfunction

    always_comb begin
        p0 = '0;
        p1 = '0;
        two = 1'b0;
        if (!req.is_write) begin
            p0.rqtype = transducer_pkg::load_rq;
            p0.size = transducer_pkg::sz_4b;
            p0.address = base;
            p0.nc = req.word_addr[transducer_pkg::cpu_addr_width-1];
            p0.last = 1'b1;
        end else begin
            case (req.be)
                4'b0001: p0 = store_piece(transducer_pkg::sz_1b, 2'd0, 1'b1);
                4'b0010: p0 = store_piece(transducer_pkg::sz_1b, 2'd1, 1'b1);
                4'b0100: p0 = store_piece(transducer_pkg::sz_1b, 2'd2, 1'b1);
                4'b1000: p0 = store_piece(transducer_pkg::sz_1b, 2'd3, 1'b1);
                4'b0011: p0 = store_piece(transducer_pkg::sz_2b, 2'd0, 1'b1);
                4'b1100: p0 = store_piece(transducer_pkg::sz_2b, 2'd2, 1'b1);
                4'b0111: begin
                    p0 = store_piece(transducer_pkg::sz_2b, 2'd0, 1'b0);
                    p1 = store_piece(transducer_pkg::sz_1b, 2'd2, 1'b1);
                    two = 1'b1;
                end
                4'b1110: begin
                    p0 = store_piece(transducer_pkg::sz_1b, 2'd1, 1'b0);
                    p1 = store_piece(transducer_pkg::sz_2b, 2'd2, 1'b1);
                    two = 1'b1;
                end
                4'b0110: begin
                    p0 = store_piece(transducer_pkg::sz_1b, 2'd1, 1'b0);
                    p1 = store_piece(transducer_pkg::sz_1b, 2'd2, 1'b1);
                    two = 1'b1;
                end
                // full word, and illegal enables fall back to it
                default: p0 = store_piece(transducer_pkg::sz_4b, 2'd0, 1'b1);
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            piece_valid <= 1'b0;
            second_pending <= 1'b0;
        end else if (req_start) begin
            piece_valid <= 1'b1;
            second_pending <= two;
        end else if (take) begin
            piece_valid <= second_pending;
            second_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_start) begin
            piece <= p0;
        end else if (take && second_pending) begin
            piece <= p1;
        end
    end

    a_legal_be: assert property (@(posedge clk) disable iff (!rst_n)
        req_start && req.is_write |-> req.be inside {4'b0001, 4'b0010, 4'b0100,
            4'b1000, 4'b0011, 4'b1100, 4'b1111, 4'b0111, 4'b1110, 4'b0110});

    // capture never starts a new request while pieces are still queued here
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        req_start |-> !piece_valid);

endmodule

// File: source/cpu_req_capture.sv
/*
 * Accepts one Avalon read or write at a time and holds it until done.
 * Bursts are not supported and burstcount is assumed to be one.
 * waitrequest is low while idle, so a request is taken at once.
 * A write releases waitrequest in the store_done cycle, a read in the
 * readdatavalid cycle.
 */
module cpu_req_capture (
    input  logic clk,
    input  logic rst_n,
    input  logic [transducer_pkg::cpu_addr_width-1:0] mem_address,
    input  logic [31:0] mem_writedata,
    input  logic [3:0] mem_byteenable,
    input  logic mem_read,
    input  logic mem_write,
    input  logic store_done,
    input  logic load_done,
    input  logic [31:0] load_word,
    output logic waitrequest,
    output logic readdatavalid,
    output logic [31:0] readdata,
    output transducer_pkg::cpu_req_t req,
    output logic req_start
);

    logic busy;
    logic accept;

    // store_done already arrives a cycle after the ack
    assign waitrequest = busy && !store_done;
    assign accept = (mem_read || mem_write) && !waitrequest;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            req_start <= 1'b0;
            readdatavalid <= 1'b0;
        end else begin
            req_start <= accept;
            readdatavalid <= load_done;
            if (accept) begin
                busy <= 1'b1;
            end else if (store_done || load_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req.word_addr <= mem_address;
            req.wdata <= mem_writedata;
            req.be <= mem_byteenable;
            req.is_write <= mem_write;
        end
        if (load_done) begin
            readdata <= load_word;
        end
    end

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write));

    // completions must match the held request
    a_store_done: assert property (@(posedge clk) disable iff (!rst_n)
        store_done |-> busy && req.is_write);
    a_load_done: assert property (@(posedge clk) disable iff (!rst_n)
        load_done |-> busy && !req.is_write);

endmodule

// File: source/transducer_pkg.sv
/*
 * Shared widths, codes and structs for the ao486 to L1.5 bridge.
 * Code values follow the L1.5 request/return port of OpenPiton.
 * Only single-beat accesses exist, so no burst or fill codes appear.
 * Interrupt type sits in bits 17:16 of return data word 0.
 */
package transducer_pkg;

    // bus widths
    localparam int unsigned phys_addr_width = 40;
    localparam int unsigned cpu_addr_width = 30;

    // request types
    localparam logic [4:0] load_rq = 5'd0;
    localparam logic [4:0] store_rq = 5'd1;

    // request sizes
    localparam logic [2:0] sz_1b = 3'd0;
    localparam logic [2:0] sz_2b = 3'd1;
    localparam logic [2:0] sz_4b = 3'd2;

    // return types
    localparam logic [3:0] load_ret = 4'd0;
    localparam logic [3:0] st_ack = 4'd4;
    localparam logic [3:0] int_ret = 4'd7;

    // interrupt type field in data_0
    localparam int unsigned int_type_lsb = 16;
    localparam logic [1:0] int_wakeup = 2'd1;

    // one captured CPU access
    typedef struct packed {
        logic [cpu_addr_width-1:0] word_addr;
        logic [31:0] wdata;
        logic [3:0] be;
        logic is_write;
    } cpu_req_t;

    // one cache request piece with right-aligned big-endian data
    typedef struct packed {
        logic [4:0] rqtype;
        logic [2:0] size;
        logic [phys_addr_width-1:0] address;
        logic [31:0] data;
        logic nc;
        logic last;
        logic is_store;
    } l15_req_t;

endpackage
